/* Makefile */
# Verilator simulation of the amplifier configuration front end.
VERILATOR ?= verilator
TOP       ?= tb_amp_cfg
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/amp_cfg_cfg.svh */
`ifndef AMP_CFG_CFG_SVH
`define AMP_CFG_CFG_SVH

// system clocks per half sclk period, any value of 1 or more.
`define AMP_CFG_SCLK_DIV 2

// registers written per configuration, 0 to 17.
`define AMP_CFG_NUM_REGS 18

// command slots in the store, addressed by a 3-bit cmd_addr.
`define AMP_CFG_NUM_CMDS 7

`endif

/* logic/amp_cfg_ifs.sv */
interface cmd_bank_if;
  logic [7:0] cmd_filt; // upper bandwidth code in 7:4, lower bandwidth code in 3:0.
  logic [7:0] cmd_mix0; // adc option in 7:4, dout enables in 3:1.
  logic [7:0] cmd_mix1; // device id in 7:4, din in 3:2, group in 1.
  logic [7:0] cmd_reg4; // raw byte for register 4.
  logic [7:0] cmd_reg5; // raw byte for register 5.
  logic [7:0] cmd_reg6; // raw byte for register 6.
  logic [7:0] cmd_reg7; // raw byte for register 7.

  modport store (output cmd_filt, cmd_mix0, cmd_mix1, cmd_reg4, cmd_reg5, cmd_reg6, cmd_reg7);
  modport mapper (input cmd_filt, cmd_mix0, cmd_mix1, cmd_reg4, cmd_reg5, cmd_reg6, cmd_reg7);
endinterface

interface reg_bank_if;
  import amp_cfg_pkg::*;

  logic [13:0][7:0] regs; // register values 0 to 13.
  logic [7:0]       regap; // amplifier power byte shared by registers 14 to 17.
  logic [3:0]       devid; // device id taken from the commands.
  logic             dev_grp; // device group bit taken from the commands.

  // byte that belongs at a given register address.
  function automatic logic [7:0] byte_at(input reg_addr_t addr);
    if (addr < reg_addr_t'(14)) begin
      return regs[addr[3:0]]; // one of the mapped registers.
    end
    return regap; // registers 14 and up all carry the power byte.
  endfunction

  modport mapper (output regs, regap, devid, dev_grp);
  modport seq (input regs, regap, import byte_at);
endinterface

/* logic/amp_cfg_pkg.sv */
package amp_cfg_pkg;

  // the sequencer walks one register per load and wait pair.
  typedef enum logic [1:0] {
    seq_idle = 2'b00, // no configuration in progress.
    seq_load = 2'b01, // frame offered to the transmitter.
    seq_wait = 2'b10  // frame accepted, waiting for the transmitter to finish.
  } seq_state_t;

  // transmitter states.
  typedef enum logic [1:0] {
    tx_idle  = 2'b00, // chip select high, ready for a frame.
    tx_shift = 2'b01, // chip select low, 16 bits on the wire.
    tx_gap   = 2'b10  // chip select high again for one half period.
  } tx_state_t;

  // top two bits of every frame sent to the chip.
  typedef enum logic [1:0] {
    op_convert = 2'b00, // start a conversion, never sent by this block.
    op_write   = 2'b10, // write the data byte to the addressed register.
    op_read    = 2'b11  // read back a register, never sent by this block.
  } frame_op_t;

  // chip register address field of a frame.
  typedef logic [5:0] reg_addr_t;

endpackage

/* logic/amp_cfg_top.sv */
module amp_cfg_top (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_wr,
  input  logic [2:0] cmd_addr,
  input  logic [7:0] cmd_data,
  input  logic       cfg_start,
  output logic       busy,
  output logic       cfg_done,
  output logic       cs_n,
  output logic       sclk,
  output logic       mosi,
  output logic [3:0] devid,
  output logic       dev_grp
);

  cmd_bank_if cmd_bank (); // command bytes from the store to the mapper.
  reg_bank_if reg_bank (); // register values from the mapper to the sequencer.

  logic        frame_load; // one-cycle offer of a frame.
  logic [15:0] frame; // opcode, address and data of the offered frame.
  logic        tx_busy; // transmitter is sending or in its gap.

  cmd_store u_cmd_store (
    .clk      (clk),
    .rst      (rst),
    .cmd_wr   (cmd_wr),
    .cmd_addr (cmd_addr),
    .cmd_data (cmd_data),
    .busy     (busy),
    .cmds     (cmd_bank)
  );

  cs_cmd2reg u_cs_cmd2reg (
    .cmds (cmd_bank),
    .regs (reg_bank)
  );

  reg_write_seq u_reg_write_seq (
    .clk        (clk),
    .rst        (rst),
    .cfg_start  (cfg_start),
    .regs       (reg_bank),
    .tx_busy    (tx_busy),
    .frame_load (frame_load),
    .frame      (frame),
    .busy       (busy),
    .cfg_done   (cfg_done)
  );

  spi_frame_tx u_spi_frame_tx (
    .clk        (clk),
    .rst        (rst),
    .frame_load (frame_load),
    .frame      (frame),
    .tx_busy    (tx_busy),
    .cs_n       (cs_n),
    .sclk       (sclk),
    .mosi       (mosi)
  );

  assign devid   = reg_bank.devid; // the id also goes to the board outside the chip.
  assign dev_grp = reg_bank.dev_grp;

endmodule

/* logic/cmd_store.sv */
`include "amp_cfg_cfg.svh"

module cmd_store (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_wr,
  input  logic [2:0] cmd_addr,
  input  logic [7:0] cmd_data,
  input  logic       busy,
  cmd_bank_if.store  cmds
);

  logic wr_en;

  assign wr_en = cmd_wr && !busy; // the chip must never see half old and half new bytes.

  always_ff @(posedge clk) begin
    if (rst) begin
      cmds.cmd_filt <= '0; // all slots start out cleared.
      cmds.cmd_mix0 <= '0;
      cmds.cmd_mix1 <= '0;
      cmds.cmd_reg4 <= '0;
      cmds.cmd_reg5 <= '0;
      cmds.cmd_reg6 <= '0;
      cmds.cmd_reg7 <= '0;
    end else if (wr_en) begin
      case (cmd_addr)
        3'd0: cmds.cmd_filt <= cmd_data; // bandwidth codes.
        3'd1: cmds.cmd_mix0 <= cmd_data; // adc option and dout enables.
        3'd2: cmds.cmd_mix1 <= cmd_data; // id, din and group bits.
        3'd3: cmds.cmd_reg4 <= cmd_data; // raw register bytes follow.
        3'd4: cmds.cmd_reg5 <= cmd_data;
        3'd5: cmds.cmd_reg6 <= cmd_data;
        3'd6: cmds.cmd_reg7 <= cmd_data;
        default: ; // address 7 has no slot and is dropped.
      endcase
    end
  end

  // the host is expected to stay inside the slot range.
  a_cmd_addr_in_range: assert property (
    @(posedge clk) disable iff (rst)
    cmd_wr |-> (cmd_addr < 3'(`AMP_CFG_NUM_CMDS))
  ) else $error("cmd_store: write to unused slot %0d", cmd_addr);

endmodule

/* logic/cs_cmd2reg.sv */
module cs_cmd2reg (
  cmd_bank_if.mapper cmds,
  reg_bank_if.mapper regs
);

  // adc bias and mux bias per sample rate option, entries 0 to 8, lowest entry last.
  localparam logic [8:0][7:0] adc_bias_tbl =
    72'h02_03_03_04_08_08_08_10_20;
  localparam logic [8:0][7:0] mux_bias_tbl =
    72'h04_07_10_12_1A_20_28_28_28;

  // upper bandwidth tables for registers 8 to 11, codes 0 to 15.
  localparam logic [15:0][7:0] rh1_dac1_tbl =
    128'h0B_11_16_21_03_0D_1B_01_2E_29_1E_06_2A_18_2C_26;
  localparam logic [15:0][7:0] rh1_dac2_tbl =
    128'h00_00_00_00_01_01_01_02_02_03_05_09_0A_0D_11_1A;
  localparam logic [15:0][7:0] rh2_dac1_tbl =
    128'h08_10_17_25_0D_19_2C_17_1E_24_2B_02_05_07_08_05;
  localparam logic [15:0][7:0] rh2_dac2_tbl =
    128'h00_00_00_00_01_01_01_02_03_04_06_0B_0D_10_15_1F;

  // lower bandwidth tables for registers 12 and 13, codes 0 to 15.
  localparam logic [15:0][7:0] rl_dac1_tbl =
    128'h0D_0F_12_19_22_36_3E_05_12_28_14_2A_08_2C_23_38;
  localparam logic [15:0][7:0] rl_dac2_tbl =
    128'h00_00_00_00_00_00_00_01_01_01_02_02_03_06_11_36;

  localparam logic [7:0] bias_byte = 8'b1101_1110; // fixed contents of register 0.
  localparam logic [3:0] adc_max   = 4'd8; // highest defined sample rate option.

  logic [3:0]       adc_sel; // sample rate option after saturation.
  logic [3:0]       upper_bw; // upper bandwidth code.
  logic [3:0]       lower_bw; // lower bandwidth code.
  logic [2:0]       dout_en; // dout enables for the three register pairs.
  logic [13:0][7:0] map; // mapped values of registers 0 to 13.

  // options 9 to 15 have no table entry, so they run at the fastest defined rate.
  assign adc_sel  = (cmds.cmd_mix0[7:4] > adc_max) ? adc_max : cmds.cmd_mix0[7:4];
  assign upper_bw = cmds.cmd_filt[7:4];
  assign lower_bw = cmds.cmd_filt[3:0];
  assign dout_en  = cmds.cmd_mix0[3:1];

  always_comb begin
    map[0]  = bias_byte; // reference bias settings.
    map[1]  = {2'b00, adc_bias_tbl[adc_sel][5:0]}; // adc buffer bias, 6 bits.
    map[2]  = {2'b00, mux_bias_tbl[adc_sel][5:0]}; // mux bias, 6 bits.
    map[3]  = {6'b00_0000, cmds.cmd_mix1[3:2]}; // digital output pins.
    map[4]  = cmds.cmd_reg4; // registers 4 to 7 go through untouched.
    map[5]  = cmds.cmd_reg5;
    map[6]  = cmds.cmd_reg6;
    map[7]  = cmds.cmd_reg7;
    map[8]  = {dout_en[2], rh1_dac1_tbl[upper_bw][6:0]}; // top bit is the dout enable of the pair.
    map[9]  = {dout_en[2], rh1_dac2_tbl[upper_bw][6:0]};
    map[10] = {dout_en[1], rh2_dac1_tbl[upper_bw][6:0]};
    map[11] = {dout_en[1], rh2_dac2_tbl[upper_bw][6:0]};
    map[12] = {dout_en[0], rl_dac1_tbl[lower_bw][6:0]};
    map[13] = {dout_en[0], rl_dac2_tbl[lower_bw][6:0]};
  end

  assign regs.regs    = map;
  assign regs.regap   = 8'hFF; // every amplifier powered up.
  assign regs.devid   = cmds.cmd_mix1[7:4]; // id follows the command byte with no delay.
  assign regs.dev_grp = cmds.cmd_mix1[1];

endmodule

/* logic/reg_write_seq.sv */
`include "amp_cfg_cfg.svh"

module reg_write_seq (
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_start,
  reg_bank_if.seq     regs,
  input  logic        tx_busy,
  output logic        frame_load,
  output logic [15:0] frame,
  output logic        busy,
  output logic        cfg_done
);

  import amp_cfg_pkg::*;

  localparam reg_addr_t last_addr = reg_addr_t'(`AMP_CFG_NUM_REGS - 1); // register 17.

  seq_state_t state; // where the walk over the registers stands.
  reg_addr_t  addr; // register whose frame is offered or in flight.

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= seq_idle;
      addr     <= '0;
      busy     <= 1'b0;
      cfg_done <= 1'b0;
    end else begin
      cfg_done <= 1'b0; // a single cycle pulse unless set below.
      case (state)
        seq_idle: begin
          if (cfg_start) begin
            state <= seq_load; // a new walk always begins at register 0.
            addr  <= '0;
            busy  <= 1'b1;
          end
        end
        seq_load: begin
          if (!tx_busy) begin
            state <= seq_wait; // the transmitter takes the frame at this edge.
          end
        end
        seq_wait: begin
          if (!tx_busy) begin
            if (addr == last_addr) begin
              state    <= seq_idle; // busy falls together with the done pulse.
              busy     <= 1'b0;
              cfg_done <= 1'b1;
            end else begin
              state <= seq_load;
              addr  <= addr + 1'b1;
            end
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

  assign frame_load = (state == seq_load) && !tx_busy; // offered only to an idle transmitter.
  assign frame      = {op_write, addr, regs.byte_at(addr)}; // opcode, address, data.

  // every load must find the transmitter idle and leave it busy on the next cycle.
  a_load_handshake: assert property (
    @(posedge clk) disable iff (rst)
    frame_load |-> !tx_busy ##1 tx_busy
  ) else $error("reg_write_seq: frame load not taken by the transmitter");

endmodule

/* logic/spi_frame_tx.sv */
`include "amp_cfg_cfg.svh"

module spi_frame_tx (
  input  logic        clk,
  input  logic        rst,
  input  logic        frame_load,
  input  logic [15:0] frame,
  output logic        tx_busy,
  output logic        cs_n,
  output logic        sclk,
  output logic        mosi
);

  import amp_cfg_pkg::*;

  localparam int half_div = `AMP_CFG_SCLK_DIV; // clocks per half sclk period.
  localparam int div_w = (half_div > 1) ? $clog2(half_div) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(half_div - 1);

  tx_state_t        state;
  logic [div_w-1:0] div_cnt; // position inside the current half period.
  logic [3:0]       bit_cnt; // bits already completed in this frame.
  logic [15:0]      shreg; // frame bits still to go, current bit on top.
  logic             half_tick;

  assign half_tick = (div_cnt == div_last); // last clock of a half period.
  assign tx_busy   = (state != tx_idle); // rises the cycle after a load.
  assign mosi      = shreg[15]; // the register empties to zero, so mosi rests low.

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= tx_idle;
      div_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '0;
      cs_n    <= 1'b1;
      sclk    <= 1'b0;
    end else begin
      case (state)
        tx_idle: begin
          if (frame_load) begin
            state   <= tx_shift; // bit 15 is set up a half period before the first rise.
            shreg   <= frame;
            cs_n    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        tx_shift: begin
          div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
          if (half_tick) begin
            sclk <= !sclk;
            if (sclk) begin
              shreg   <= {shreg[14:0], 1'b0}; // next bit moves out on the falling edge.
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 4'd15) begin
                state <= tx_gap; // sixteenth falling edge ends the frame.
                cs_n  <= 1'b1;
              end
            end
          end
        end
        tx_gap: begin
          div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
          if (half_tick) begin
            state <= tx_idle; // chip select has been high for one half period.
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  a_sclk_idle_low: assert property (
    @(posedge clk) disable iff (rst)
    cs_n |-> !sclk
  ) else $error("spi_frame_tx: sclk high with chip select released");

endmodule

/* sim/tb_amp_cfg.sv */
`include "amp_cfg_cfg.svh"

module tb_amp_cfg;
  timeunit 1ns;
  timeprecision 100ps;

  import amp_cfg_pkg::*;

  localparam int num_rows    = 16; // one row per bandwidth and adc code.
  localparam int num_fill    = 4; // random filler configurations after the table.
  localparam int intrude_row = 5; // this row also sees a write and a start while busy.
  localparam int num_cfgs    = num_rows + num_fill + 1; // the intruded row runs twice.
  localparam int wd_cycles   =
    num_cfgs * (`AMP_CFG_NUM_REGS * 40 * `AMP_CFG_SCLK_DIV + 40) + 200; // a frame is < 40 half periods.

  // filt mix0 mix1 reg4 reg5 reg6 reg7, then expected registers 1 2 8 9 10 11 12 13.
  localparam logic [119:0] rows [num_rows] = '{
    120'h0F_00_00_A0_05_5F_30_20_28_26_1A_05_1F_0D_00,
    120'h1E_12_11_A1_15_5E_31_10_28_2C_11_08_15_8F_80,
    120'h2D_24_22_A2_25_5D_32_08_28_18_0D_87_90_12_00,
    120'h3C_36_33_A3_35_5C_33_08_20_2A_0A_85_8D_99_80,
    120'h4B_48_44_A4_45_5B_34_08_1A_86_89_02_0B_22_00,
    120'h5A_5A_55_A5_55_5A_35_04_12_9E_85_2B_06_B6_80,
    120'h69_6C_66_A6_65_59_36_03_10_A9_83_A4_84_3E_00,
    120'h78_7E_77_A7_75_58_37_03_07_AE_82_9E_83_85_81,
    120'h87_80_88_A8_85_57_38_02_04_01_02_17_02_12_01,
    120'h96_92_99_A9_95_56_39_02_04_1B_01_2C_01_A8_81,
    120'hA5_A4_AA_AA_A5_55_3A_02_04_0D_01_99_81_14_02,
    120'hB4_B6_BB_AB_B5_54_3B_02_04_03_01_8D_81_AA_82,
    120'hC3_C8_CC_AC_C5_53_3C_02_04_A1_80_25_00_08_03,
    120'hD2_DA_DD_AD_D5_52_3D_02_04_96_80_17_00_AC_86,
    120'hE1_EC_EE_AE_E5_51_3E_02_04_91_80_90_80_23_11,
    120'hF0_FE_FF_AF_F5_50_3F_02_04_8B_80_88_80_B8_B6
  };

  logic        clk;
  logic        rst;
  logic        cmd_wr;
  logic [2:0]  cmd_addr;
  logic [7:0]  cmd_data;
  logic        cfg_start;
  logic        busy;
  logic        cfg_done;
  logic        cs_n;
  logic        sclk;
  logic        mosi;
  logic [3:0]  devid;
  logic        dev_grp;

  logic [7:0]  cmd_bytes [7]; // slot contents of the configuration under test.
  logic [7:0]  exp_regs [`AMP_CFG_NUM_REGS]; // expected data byte per register address.
  logic [17:0] exp_mask; // addresses whose data byte is compared.
  logic [15:0] frames [$]; // every frame seen on the serial port, in order.
  logic [15:0] rx_shift; // bits of the frame being received.
  int          rx_bits = 0;
  int          cut_frames = 0; // frames that lost chip select early.
  int          done_pulses = 0;
  int          errors;
  int          checks;
  logic [31:0] lfsr_state;

  amp_cfg_top UUT (
    .clk       (clk),
    .rst       (rst),
    .cmd_wr    (cmd_wr),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .cfg_start (cfg_start),
    .busy      (busy),
    .cfg_done  (cfg_done),
    .cs_n      (cs_n),
    .sclk      (sclk),
    .mosi      (mosi),
    .devid     (devid),
    .dev_grp   (dev_grp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period.
  end

  // the chip samples mosi on rising sclk, so the monitor does the same.
  always @(posedge sclk or posedge cs_n) begin
    if (cs_n) begin
      if (rx_bits != 0) begin
        cut_frames++; // chip select rose in the middle of a frame.
      end
      rx_bits = 0;
    end else begin
      rx_shift = {rx_shift[14:0], mosi}; // msb arrives first.
      rx_bits++;
      if (rx_bits == 16) begin
        frames.push_back(rx_shift);
        rx_bits = 0;
      end
    end
  end

  always @(negedge clk) begin
    if (cfg_done === 1'b1) begin
      done_pulses++; // each high cycle counts as one pulse.
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2 and 1.
  endfunction

  task automatic next_rand_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_step(lfsr_state); // one step per bit taken.
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  // called on a falling edge, returns on the falling edge after the store took the byte.
  task automatic write_cmd(input logic [2:0] addr, input logic [7:0] data);
    cmd_wr   = 1'b1;
    cmd_addr = addr;
    cmd_data = data;
    @(negedge clk);
    cmd_wr = 1'b0;
  endtask

  task automatic load_cmds();
    for (int s = 0; s < 7; s++) begin
      write_cmd(3'(s), cmd_bytes[s]);
      if (s == 2) begin
        check_value("devid", 32'(devid), 32'(cmd_bytes[2][7:4])); // visible one cycle on.
        check_value("dev_grp", 32'(dev_grp), 32'(cmd_bytes[2][1]));
      end
    end
  endtask

  // registers that follow from fixed rules rather than the lookup tables.
  task automatic derive_rule_regs();
    for (int k = 0; k < `AMP_CFG_NUM_REGS; k++) begin
      exp_regs[k] = 8'h00;
    end
    exp_regs[0] = 8'b1101_1110; // fixed bias byte.
    exp_regs[3] = {6'b00_0000, cmd_bytes[2][3:2]}; // din bits.
    for (int k = 4; k < 8; k++) begin
      exp_regs[k] = cmd_bytes[k - 1]; // raw bytes pass straight through.
    end
    for (int k = 14; k < `AMP_CFG_NUM_REGS; k++) begin
      exp_regs[k] = 8'hFF; // amplifier power byte.
    end
    exp_mask = 18'b11_1100_0000_1111_1001;
  endtask

  task automatic run_config(input bit intrude);
    int          first;
    int          dones;
    int          n;
    logic [15:0] f;
    first = frames.size();
    dones = done_pulses;
    cfg_start = 1'b1;
    @(negedge clk);
    cfg_start = 1'b0;
    check_value("busy", 32'(busy), 32'd1);
    if (intrude) begin
      cmd_wr    = 1'b1; // both of these must be ignored while busy.
      cmd_addr  = 3'd3;
      cmd_data  = ~cmd_bytes[3];
      cfg_start = 1'b1;
      @(negedge clk);
      cmd_wr    = 1'b0;
      cfg_start = 1'b0;
    end
    while (cfg_done !== 1'b1) begin
      @(negedge clk); // the watchdog bounds this wait.
    end
    check_value("busy", 32'(busy), 32'd0); // busy falls with the done pulse.
    @(negedge clk);
    check_value("cfg_done", 32'(cfg_done), 32'd0);
    @(posedge clk); // counters settle on the falling edge, read them away from it.
    check_value("cfg_done pulses", 32'(done_pulses - dones), 32'd1);
    n = frames.size() - first;
    check_value("frame count", 32'(n), 32'(`AMP_CFG_NUM_REGS));
    if (n > `AMP_CFG_NUM_REGS) begin
      n = `AMP_CFG_NUM_REGS;
    end
    for (int k = 0; k < n; k++) begin
      f = frames[first + k];
      check_value($sformatf("frame %0d opcode", k), 32'(f[15:14]), 32'(op_write));
      check_value($sformatf("frame %0d address", k), 32'(f[13:8]), 32'(k));
      if (exp_mask[k]) begin
        check_value($sformatf("frame %0d data", k), 32'(f[7:0]), 32'(exp_regs[k]));
      end
    end
    @(negedge clk);
  endtask

  initial begin
    rst        = 1'b1;
    cmd_wr     = 1'b0;
    cmd_addr   = 3'd0;
    cmd_data   = 8'h00;
    cfg_start  = 1'b0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'h806ef9b5;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    check_value("cs_n", 32'(cs_n), 32'd1); // idle levels before any start.
    check_value("busy", 32'(busy), 32'd0);
    check_value("cfg_done", 32'(cfg_done), 32'd0);
    check_value("sclk", 32'(sclk), 32'd0);
    check_value("mosi", 32'(mosi), 32'd0);
    for (int r = 0; r < num_rows; r++) begin
      for (int s = 0; s < 7; s++) begin
        cmd_bytes[s] = rows[r][119 - 8 * s -: 8];
      end
      derive_rule_regs();
      for (int t = 0; t < 8; t++) begin
        exp_regs[(t < 2) ? t + 1 : t + 6] = rows[r][63 - 8 * t -: 8]; // registers 1, 2, 8 to 13.
        exp_mask[(t < 2) ? t + 1 : t + 6] = 1'b1;
      end
      load_cmds();
      run_config(r == intrude_row);
      if (r == intrude_row) begin
        run_config(1'b0); // a plain restart must replay the bytes from before the busy write.
      end
    end
    for (int i = 0; i < num_fill; i++) begin
      for (int s = 0; s < 7; s++) begin
        next_rand_byte(cmd_bytes[s]);
      end
      derive_rule_regs();
      load_cmds();
      run_config(1'b0);
    end
    if (cut_frames != 0) begin
      $display("%0d frames ended before all 16 bits were sent", cut_frames);
      errors += cut_frames;
    end
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d clock cycles with the run unfinished", wd_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+logic
logic/amp_cfg_pkg.sv
logic/amp_cfg_ifs.sv
logic/cmd_store.sv
logic/cs_cmd2reg.sv
logic/reg_write_seq.sv
logic/spi_frame_tx.sv
logic/amp_cfg_top.sv
sim/tb_amp_cfg.sv
